// File: tr_sync.f
design/tr_sync_pkg.sv
design/sync_sequencer.sv
design/correlator_lane.sv
design/peak_picker.sv
design/tr_sync_top.sv
dv/tr_sync_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the tr_sync testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f tr_sync.f --top-module tr_sync_tb -o tr_sync_sim \
    > build.log 2>&1 \
    && ./obj_dir/tr_sync_sim 2>&1 | tee sim.log \
    || echo "build failed, see build.log"

grep -qx "NO ERRORS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: dv/tr_sync_stim.txt
# name  code(hex)  delay  phase  amplitude  noise  expected_lane
# sample = noise in +-noise, plus amplitude times code sign of chip c-delay at the given phase
d0_p0 8F3A19C5 0 0 8000 100 0
d0_p1 5B2E07D3 0 1 3000 40 1
d0_p2 E4716AB9 0 2 12000 150 2
d0_p3 3C9D52E1 0 3 500 0 3
d0_p4 71A4C60F 0 4 8000 100 4
d1_p0 2D6B9E38 1 0 8000 100 5
d1_p1 C35A8E17 1 1 3000 40 6
d1_p2 9E0B4D72 1 2 12000 150 7
d1_p3 6A1F3C85 1 3 500 0 8
d1_p4 B7D24E09 1 4 8000 100 9
zero_data 8F3A19C5 0 0 0 0 0
d1_p4_again 8F3A19C5 1 4 3000 40 9
d0_p2_again FFFF0000 0 2 8000 100 2

// File: dv/tr_sync_tb.sv
/*
 * testbench for the frame-sync correlator
 * clock, reset, stim file reader, waveform generator, reference model, checks
 */

`timescale 1ns/100ps

module tr_sync_tb
    import tr_sync_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int NUM_SAMPLES    = (CODE_LEN + 1) * NUM_PHASES;   // chips 0..32
    localparam int FINISH_TIMEOUT = 200;                           // cycles after last sample
    localparam int HOLD_CYCLES    = 40;                            // covers the end of the run

    logic      logic_clk_in;
    logic      logic_rst_in;
    sample_t   data_in;
    logic      tr_syn_en;
    code_t     tr_syn_code;
    lane_idx_t tr_position_out;
    logic      tr_syn_finish_out;

    integer    seed = 32'h34e3_9da5;
    int        finish_cnt;
    sample_t   samples [NUM_SAMPLES];

    tr_sync_top DUT (
        .logic_clk_in      (logic_clk_in),
        .logic_rst_in      (logic_rst_in),
        .data_in           (data_in),
        .tr_syn_en         (tr_syn_en),
        .tr_syn_code       (tr_syn_code),
        .tr_position_out   (tr_position_out),
        .tr_syn_finish_out (tr_syn_finish_out)
    );

    initial
    begin
        logic_clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) logic_clk_in = ~logic_clk_in;
    end

    // finish pulses seen so far
    always @(posedge logic_clk_in)
    begin
        if (logic_rst_in)
            finish_cnt <= 0;
        else if (tr_syn_finish_out)
            finish_cnt <= finish_cnt + 1;
    end

    ////////////////////////////////////////
    // checks and failures
    task automatic check_value(input string what, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("** Error: %s expected %0d actual %0d", what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    ////////////////////////////////////////
    // waveform and reference model
    task automatic build_samples(input code_t code, input int delay, input int phase,
                                 input int amp, input int noise);
        int v;
        for (int c = 0; c <= CODE_LEN; c++)
        begin
            for (int ph = 0; ph < NUM_PHASES; ph++)
            begin
                v = $random(seed) % (noise + 1);                  // within +-noise
                if ((ph == phase) && (c >= delay) && (c - delay < CODE_LEN))
                    v = v + (code[CODE_LEN - 1 - (c - delay)] ? amp : -amp);
                samples[c * NUM_PHASES + ph] = sample_t'(v);
            end
        end
    endtask

    // lane = align*5 + phase, chip align+j weighted by code bit j, msb first
    function automatic int predict_lane(input code_t code);
        longint sum;
        longint best_sum;
        int     best;
        int     k;
        best     = 0;
        best_sum = 0;
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            sum = 0;
            for (int j = 0; j < CODE_LEN; j++)
            begin
                k = (lane / NUM_PHASES + j) * NUM_PHASES + lane % NUM_PHASES;
                sum = code[CODE_LEN - 1 - j] ? sum + longint'(samples[k])
                                             : sum - longint'(samples[k]);
            end
            if ((lane == 0) || (sum > best_sum))      // ties keep the lower lane
            begin
                best     = lane;
                best_sum = sum;
            end
        end
        return best;
    endfunction

    ////////////////////////////////////////
    // one arming, one run, one result
    task automatic run_test(input string name, input code_t code, input int delay,
                            input int phase, input int amp, input int noise,
                            input int expected, input bit hold_en);
        int        predicted;
        int        cnt_before;
        int        waited;
        lane_idx_t pos;
        build_samples(code, delay, phase, amp, noise);
        predicted = predict_lane(code);
        check_value({name, " reference"}, expected, predicted);
        cnt_before = finish_cnt;
        @(posedge logic_clk_in);
        tr_syn_en   <= 1'b1;
        tr_syn_code <= code;
        @(posedge logic_clk_in);
        tr_syn_en <= hold_en;                         // ignored while running
        for (int k = 0; k < NUM_SAMPLES; k++)
        begin
            data_in <= samples[k];
            repeat (CLKS_PER_SAMPLE) @(posedge logic_clk_in);
        end
        tr_syn_en <= 1'b0;
        data_in   <= '0;
        waited = 0;
        while (finish_cnt == cnt_before)
        begin
            @(negedge logic_clk_in);
            waited++;
            if (waited > FINISH_TIMEOUT)
                report_failure({"no finish pulse after the run in test ", name});
        end
        pos = tr_position_out;
        check_value({name, " position"}, predicted, int'(pos));
        // no second pulse, position held
        for (int i = 0; i < HOLD_CYCLES; i++)
        begin
            @(negedge logic_clk_in);
            check_value({name, " finish count"}, cnt_before + 1, finish_cnt);
            check_value({name, " held position"}, int'(pos), int'(tr_position_out));
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    initial
    begin
        int                fd;
        int                fields;
        int                num_tests;
        string             line;
        logic [8*16-1:0]   name_vec;
        code_t             code;
        int                delay;
        int                phase;
        int                amp;
        int                noise;
        int                expected;
        logic_rst_in <= 1'b1;
        data_in      <= '0;
        tr_syn_en    <= 1'b0;
        tr_syn_code  <= '0;
        repeat (3) @(posedge logic_clk_in);
        logic_rst_in <= 1'b0;
        for (int i = 0; i < 20; i++)
        begin
            @(negedge logic_clk_in);
            check_value("idle finish", 0, int'(tr_syn_finish_out));
            check_value("idle position", 0, int'(tr_position_out));
        end
        fd = $fopen("dv/tr_sync_stim.txt", "r");
        if (fd == 0)
            report_failure("could not open dv/tr_sync_stim.txt");
        num_tests = 0;
        while (!$feof(fd))
        begin
            if ($fgets(line, fd) == 0)
                break;
            if ((line.len() == 0) || (line[0] == "#"))
                continue;
            fields = $sscanf(line, "%s %h %d %d %d %d %d", name_vec, code, delay, phase,
                             amp, noise, expected);
            if (fields == 7)
            begin
                run_test($sformatf("%0s", name_vec), code, delay, phase, amp, noise,
                         expected, (num_tests % 2) == 1);   // odd tests hold enable high
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0)
            report_failure("the stim file held no test cases");
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: design/tr_sync_top.sv
/*
 * frame-sync correlator top level
 * sequencer, ten correlation lanes, peak picker
 */

`timescale 1ns/100ps

module tr_sync_top
    import tr_sync_pkg::*;
(
    input  logic      logic_clk_in,
    input  logic      logic_rst_in,
    input  sample_t   data_in,            // held 8 clocks per sample
    input  logic      tr_syn_en,
    input  code_t     tr_syn_code,
    output lane_idx_t tr_position_out,
    output logic      tr_syn_finish_out
);

    lane_ctl_t lane_ctl [NUM_LANES];
    acc_t      lane_acc [NUM_LANES];
    logic      search_start;

    ////////////////////////////////////////
    // timing and code
    sync_sequencer u_seq (
        .logic_clk_in (logic_clk_in),
        .logic_rst_in (logic_rst_in),
        .tr_syn_en    (tr_syn_en),
        .tr_syn_code  (tr_syn_code),
        .lane_ctl     (lane_ctl),
        .search_start (search_start)
    );

    // lanes 0-4 chips 0-31, lanes 5-9 chips 1-32
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        correlator_lane u_lane (
            .logic_clk_in (logic_clk_in),
            .logic_rst_in (logic_rst_in),
            .ctl          (lane_ctl[i]),
            .data_in      (data_in),
            .acc          (lane_acc[i])
        );
    end

    ////////////////////////////////////////
    // result
    peak_picker u_pick (
        .logic_clk_in      (logic_clk_in),
        .logic_rst_in      (logic_rst_in),
        .search_start      (search_start),
        .lane_acc          (lane_acc),
        .tr_position_out   (tr_position_out),
        .tr_syn_finish_out (tr_syn_finish_out)
    );

endmodule

// File: design/peak_picker.sv
/*
 * peak search over the lane sums
 * one lane per clock, strict greater-than, position and finish registers
 */

`timescale 1ns/100ps

module peak_picker
    import tr_sync_pkg::*;
(
    input  logic      logic_clk_in,
    input  logic      logic_rst_in,
    input  logic      search_start,
    input  acc_t      lane_acc [NUM_LANES],
    output lane_idx_t tr_position_out,
    output logic      tr_syn_finish_out
);

    pick_state_e state;
    lane_idx_t   lane_cnt;      // lane under test, NUM_LANES means done
    acc_t        best_val;
    lane_idx_t   best_idx;
    logic        scan_done;

    assign scan_done = (lane_cnt == 4'(NUM_LANES));

    ////////////////////////////////////////
    // scan FSM and outputs
    always_ff @(posedge logic_clk_in)
    begin
        if (logic_rst_in)
        begin
            state             <= PICK_IDLE;
            lane_cnt          <= '0;
            tr_position_out   <= '0;
            tr_syn_finish_out <= 1'b0;
        end
        else
        begin
            tr_syn_finish_out <= 1'b0;
            case (state)
                PICK_IDLE:
                begin
                    lane_cnt <= '0;
                    if (search_start)
                        state <= PICK_SCAN;
                end
                PICK_SCAN:
                begin
                    if (scan_done)
                    begin
                        tr_position_out   <= best_idx;  // held until next run
                        tr_syn_finish_out <= 1'b1;
                        state             <= PICK_IDLE;
                    end
                    else
                        lane_cnt <= lane_cnt + 4'd1;
                end
                default: state <= PICK_IDLE;
            endcase
        end
    end

    // lane 0 seeds the best, later ties keep the lower lane
    always_ff @(posedge logic_clk_in)
    begin
        if ((state == PICK_SCAN) && !scan_done)
        begin
            if ((lane_cnt == 4'd0) || (lane_acc[lane_cnt] > best_val))
            begin
                best_val <= lane_acc[lane_cnt];
                best_idx <= lane_cnt;
            end
        end
    end

endmodule

// File: design/correlator_lane.sv
/*
 * single correlation lane
 * signed add/subtract accumulator with clear
 */

`timescale 1ns/100ps

module correlator_lane
    import tr_sync_pkg::*;
(
    input  logic      logic_clk_in,
    input  logic      logic_rst_in,
    input  lane_ctl_t ctl,
    input  sample_t   data_in,
    output acc_t      acc
);

    acc_t sample_ext;

    assign sample_ext = acc_t'(data_in);    // sign extended to sum width

    ////////////////////////////////////////
    // bipolar accumulate
    always_ff @(posedge logic_clk_in)
    begin
        if (logic_rst_in)
        begin
            acc <= '0;
        end
        else if (ctl.clear)
        begin
            acc <= '0;                      // new run
        end
        else if (ctl.sample_en)
        begin
            if (ctl.code_bit)
                acc <= acc + sample_ext;    // chip +1
            else
                acc <= acc - sample_ext;    // chip -1
        end
    end

endmodule

// File: design/sync_sequencer.sv
/*
 * run sequencer for the sync correlator
 * arming FSM, chip and clock counters, code shift registers, lane control decode
 */

`timescale 1ns/100ps

module sync_sequencer
    import tr_sync_pkg::*;
(
    input  logic      logic_clk_in,
    input  logic      logic_rst_in,
    input  logic      tr_syn_en,
    input  code_t     tr_syn_code,
    output lane_ctl_t lane_ctl [NUM_LANES],
    output logic      search_start
);

    seq_state_e           state;
    logic [5:0]           chip_cnt;       // 0..END_CHIP
    logic [5:0]           clk_cnt;        // 0..39 inside a chip
    code_t                code_sr [NUM_ALIGN];
    logic                 load;
    logic                 run;
    logic                 slot;
    logic [2:0]           phase;
    logic                 last_phase;
    logic [NUM_ALIGN-1:0] win;

    ////////////////////////////////////////
    // decode of the current position
    assign load       = (state == SEQ_IDLE) && tr_syn_en;
    assign run        = (state == SEQ_RUN);
    assign phase      = 3'(clk_cnt / 6'(CLKS_PER_SAMPLE));
    assign last_phase = (phase == 3'(NUM_PHASES - 1));

    // sample slots at counts 0, 8, 16, 24, 32
    assign slot = run && ((clk_cnt % 6'(CLKS_PER_SAMPLE)) == 6'd0);

    assign search_start = run && (chip_cnt == 6'(SEARCH_CHIP)) && (clk_cnt == 6'd0);

    // alignment a sums chips a .. a+31
    always_comb
    begin
        for (int a = 0; a < NUM_ALIGN; a++)
        begin
            win[a] = (chip_cnt >= 6'(a)) && (chip_cnt < 6'(a + CODE_LEN));
        end
    end

    ////////////////////////////////////////
    // run FSM and counters
    always_ff @(posedge logic_clk_in)
    begin
        if (logic_rst_in)
        begin
            state    <= SEQ_IDLE;
            chip_cnt <= '0;
            clk_cnt  <= '0;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                begin
                    chip_cnt <= '0;
                    clk_cnt  <= '0;
                    if (tr_syn_en)
                        state <= SEQ_RUN;
                end
                SEQ_RUN:
                begin
                    if ((chip_cnt == 6'(END_CHIP)) && (clk_cnt == 6'd0))
                        state <= SEQ_IDLE;      // enable is not looked at until here
                    else if (clk_cnt == 6'(CLKS_PER_CHIP - 1))
                    begin
                        clk_cnt  <= '0;
                        chip_cnt <= chip_cnt + 6'd1;
                    end
                    else
                        clk_cnt <= clk_cnt + 6'd1;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // code registers, one per alignment
    always_ff @(posedge logic_clk_in)
    begin
        for (int a = 0; a < NUM_ALIGN; a++)
        begin
            if (load)
                code_sr[a] <= tr_syn_code;
            else if (slot && last_phase && win[a])
                code_sr[a] <= {code_sr[a][CODE_LEN-2:0], 1'b0};   // next chip after phase 4
        end
    end

    // lane i is phase i%5 of alignment i/5
    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            lane_ctl[i].clear     = load;
            lane_ctl[i].sample_en = slot && (phase == 3'(i % NUM_PHASES))
                                    && win[i / NUM_PHASES];
            lane_ctl[i].code_bit  = code_sr[i / NUM_PHASES][CODE_LEN-1];
        end
    end

endmodule

// File: design/tr_sync_pkg.sv
/*
 * frame-sync correlator shared definitions
 * timing and size constants, sample/sum/code types, lane control struct, FSM states
 */

package tr_sync_pkg;

    ////////////////////////////////////////
    // timing and sizes
    localparam int CLKS_PER_SAMPLE = 8;                             // 25 MHz samples on 200 MHz
    localparam int NUM_PHASES      = 5;                             // samples per chip
    localparam int CLKS_PER_CHIP   = CLKS_PER_SAMPLE * NUM_PHASES;
    localparam int CODE_LEN        = 32;                            // chips summed per lane
    localparam int NUM_ALIGN       = 2;                             // chip 0 and chip 1 starts
    localparam int NUM_LANES       = NUM_PHASES * NUM_ALIGN;
    localparam int SEARCH_CHIP     = 33;                            // peak search kicks off here
    localparam int END_CHIP        = 34;                            // run ends here

    ////////////////////////////////////////
    // data types
    typedef logic signed [15:0]         sample_t;
    typedef logic signed [31:0]         acc_t;
    typedef logic        [CODE_LEN-1:0] code_t;      // msb goes first
    typedef logic        [3:0]          lane_idx_t;

    // per-lane strobes from the sequencer
    typedef struct packed {
        logic clear;        // zero the sum
        logic sample_en;    // take data_in this cycle
        logic code_bit;     // 1 adds, 0 subtracts
    } lane_ctl_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    typedef enum logic {
        PICK_IDLE,
        PICK_SCAN
    } pick_state_e;

endpackage
